/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_backend_top
FILELIST  = tb.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

/* source/alu_issue_queue.sv */
`timescale 1ns/1ps

module alu_issue_queue
    import backend_pkg::*;
#(
    parameter int  PHYS_REGS = 16,
    parameter int  IQ_DEPTH  = 4,
    parameter int  ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(PHYS_REGS),
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH),
    localparam int RUOP_W    = $bits(uop_t) + 3 * TAG_W + ROB_IDX_W,
    localparam int WB_W      = 1 + TAG_W + ROB_IDX_W + DATA_W
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 enq_i,
    input  logic [RUOP_W-1:0]    enq_uop_i,
    output logic                 full_o,
    input  logic [PHYS_REGS-1:0] busy_i,
    input  logic [WB_W-1:0]      wb_i,
    output logic                 issue_valid_o,
    output logic [RUOP_W-1:0]    issue_uop_o
);

    localparam int IDX_W = $clog2(IQ_DEPTH);
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    typedef struct packed {
        uop_t                 uop;
        logic [TAG_W-1:0]     prd;
        logic [TAG_W-1:0]     ps1;
        logic [TAG_W-1:0]     ps2;
        logic [ROB_IDX_W-1:0] rob_idx;
    } renamed_uop_t;

    typedef struct packed {
        logic                 valid;
        logic [TAG_W-1:0]     prd;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [DATA_W-1:0]    data;
    } wb_info_t;

    renamed_uop_t         q [IQ_DEPTH];
    renamed_uop_t         enq_uop;
    wb_info_t             wb;
    logic [CNT_W-1:0]     count;
    logic [IQ_DEPTH-1:0]  rdy;
    logic [IDX_W-1:0]     sel_idx;
    logic [IDX_W-1:0]     wr_idx;

    assign enq_uop = enq_uop_i;
    assign wb      = wb_i;
    assign full_o  = (count == CNT_W'(IQ_DEPTH));

    // a source is ready once its busy bit drops or its writeback is on the bus now
    function automatic logic src_ok(input logic [TAG_W-1:0] tag);
        return !busy_i[tag] || (wb.valid && (wb.prd == tag));
    endfunction

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            rdy[i] = (CNT_W'(i) < count) &&
                     ((q[i].uop.op == OP_LI) || (src_ok(q[i].ps1) && src_ok(q[i].ps2)));
        end
    end

    // entry 0 is the oldest, lowest ready index wins
    always_comb begin
        issue_valid_o = 1'b0;
        sel_idx       = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (rdy[i]) begin
                issue_valid_o = 1'b1;
                sel_idx       = IDX_W'(i);
            end
        end
    end

    assign issue_uop_o = q[sel_idx];
    assign wr_idx      = IDX_W'(count - CNT_W'(issue_valid_o));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(enq_i) - CNT_W'(issue_valid_o);
        end
    end

    // compact above the issued slot, new entry goes behind the survivors
    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH - 1; i++) begin
            if (issue_valid_o && (IDX_W'(i) >= sel_idx)) begin
                q[i] <= q[i + 1];
            end
        end
        if (enq_i) begin
            q[wr_idx] <= enq_uop;
        end
    end

    a_no_enq_full: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        enq_i |-> !full_o
    ) else $error("alu_issue_queue: enqueue while full");

endmodule

/* source/backend_pkg.sv */
package backend_pkg;

    // architectural state
    localparam int ARCH_REGS = 8;
    localparam int DATA_W    = 32;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;

    // OP_LI ignores both sources and writes imm
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_LI  = 3'd5
    } alu_op_e;

    // micro-op as it enters the backend
    typedef struct packed {
        alu_op_e           op;
        arch_reg_t         rd;
        arch_reg_t         rs1;
        arch_reg_t         rs2;
        logic [DATA_W-1:0] imm;
    } uop_t;

    // in-order result leaving the reorder buffer
    typedef struct packed {
        arch_reg_t         rd;
        logic [DATA_W-1:0] data;
    } retire_t;

endpackage

/* source/backend_top.sv */
`timescale 1ns/1ps

module backend_top
    import backend_pkg::*;
#(
    parameter int PHYS_REGS = 16,
    parameter int IQ_DEPTH  = 4,
    parameter int ROB_DEPTH = 8
) (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    uop_valid_i,
    input  uop_t    uop_i,
    output logic    uop_ready_o,
    output logic    retire_valid_o,
    output retire_t retire_o,
    input  logic    retire_ready_i
);

    localparam int TAG_W     = $clog2(PHYS_REGS);
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

    typedef struct packed {
        uop_t                 uop;
        logic [TAG_W-1:0]     prd;
        logic [TAG_W-1:0]     ps1;
        logic [TAG_W-1:0]     ps2;
        logic [ROB_IDX_W-1:0] rob_idx;
    } renamed_uop_t;

    typedef struct packed {
        logic                 valid;
        logic [TAG_W-1:0]     prd;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [DATA_W-1:0]    data;
    } wb_info_t;

    logic                 accept;
    logic                 free_empty;
    logic                 iq_full;
    logic                 rob_full;
    logic [TAG_W-1:0]     prd;
    logic [TAG_W-1:0]     ps1;
    logic [TAG_W-1:0]     ps2;
    logic [TAG_W-1:0]     old_prd;
    logic [ROB_IDX_W-1:0] rob_idx;
    logic [PHYS_REGS-1:0] busy;
    renamed_uop_t         enq_uop;
    logic                 issue_valid;
    renamed_uop_t         issue_uop;
    wb_info_t             wb;
    logic                 release_v;
    logic [TAG_W-1:0]     release_tag;

    // a uop needs a free tag, an IQ slot and a ROB slot
    assign uop_ready_o = !free_empty && !iq_full && !rob_full;
    assign accept      = uop_valid_i && uop_ready_o;
    assign enq_uop     = '{uop: uop_i, prd: prd, ps1: ps1, ps2: ps2, rob_idx: rob_idx};

    rename_map #(.PHYS_REGS(PHYS_REGS)) rename_map_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .alloc_i       (accept),
        .rd_i          (uop_i.rd),
        .rs1_i         (uop_i.rs1),
        .rs2_i         (uop_i.rs2),
        .prd_o         (prd),
        .ps1_o         (ps1),
        .ps2_o         (ps2),
        .old_prd_o     (old_prd),
        .free_empty_o  (free_empty),
        .release_i     (release_v),
        .release_tag_i (release_tag)
    );

    busy_table #(.PHYS_REGS(PHYS_REGS)) busy_table_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .set_i     (accept),
        .set_tag_i (prd),
        .clr_i     (wb.valid),
        .clr_tag_i (wb.prd),
        .busy_o    (busy)
    );

    alu_issue_queue #(
        .PHYS_REGS (PHYS_REGS),
        .IQ_DEPTH  (IQ_DEPTH),
        .ROB_DEPTH (ROB_DEPTH)
    ) alu_issue_queue_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .enq_i         (accept),
        .enq_uop_i     (enq_uop),
        .full_o        (iq_full),
        .busy_i        (busy),
        .wb_i          (wb),
        .issue_valid_o (issue_valid),
        .issue_uop_o   (issue_uop)
    );

    reorder_buffer #(
        .PHYS_REGS (PHYS_REGS),
        .ROB_DEPTH (ROB_DEPTH)
    ) reorder_buffer_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .alloc_i        (accept),
        .rd_i           (uop_i.rd),
        .old_prd_i      (old_prd),
        .alloc_idx_o    (rob_idx),
        .full_o         (rob_full),
        .wb_i           (wb),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .retire_ready_i (retire_ready_i),
        .release_o      (release_v),
        .release_tag_o  (release_tag)
    );

    exec_stage #(
        .PHYS_REGS (PHYS_REGS),
        .ROB_DEPTH (ROB_DEPTH)
    ) exec_stage_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid),
        .issue_uop_i   (issue_uop),
        .wb_o          (wb)
    );

endmodule

/* source/busy_table.sv */
`timescale 1ns/1ps

module busy_table #(
    parameter int  PHYS_REGS = 16,
    localparam int TAG_W     = $clog2(PHYS_REGS)
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 set_i,
    input  logic [TAG_W-1:0]     set_tag_i,
    input  logic                 clr_i,
    input  logic [TAG_W-1:0]     clr_tag_i,
    output logic [PHYS_REGS-1:0] busy_o
);

    logic [PHYS_REGS-1:0] busy_q;

    assign busy_o = busy_q;

    // set and clear never hit the same tag, so both apply
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            if (clr_i) begin
                busy_q[clr_tag_i] <= 1'b0;
            end
            if (set_i) begin
                busy_q[set_tag_i] <= 1'b1;
            end
        end
    end

    // a tag handed out by the free list has no producer in flight
    a_set_idle_tag: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        set_i |-> !busy_q[set_tag_i]
    ) else $error("busy_table: tag reallocated while still busy");

endmodule

/* source/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage
    import backend_pkg::*;
#(
    parameter int  PHYS_REGS = 16,
    parameter int  ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(PHYS_REGS),
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH),
    localparam int RUOP_W    = $bits(uop_t) + 3 * TAG_W + ROB_IDX_W,
    localparam int WB_W      = 1 + TAG_W + ROB_IDX_W + DATA_W
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              issue_valid_i,
    input  logic [RUOP_W-1:0] issue_uop_i,
    output logic [WB_W-1:0]   wb_o
);

    typedef struct packed {
        uop_t                 uop;
        logic [TAG_W-1:0]     prd;
        logic [TAG_W-1:0]     ps1;
        logic [TAG_W-1:0]     ps2;
        logic [ROB_IDX_W-1:0] rob_idx;
    } renamed_uop_t;

    typedef struct packed {
        logic                 valid;
        logic [TAG_W-1:0]     prd;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [DATA_W-1:0]    data;
    } wb_info_t;

    renamed_uop_t      iss;
    wb_info_t          wb_q;
    logic [DATA_W-1:0] rf [PHYS_REGS];
    logic [DATA_W-1:0] src1;
    logic [DATA_W-1:0] src2;
    logic [DATA_W-1:0] result;

    assign iss  = issue_uop_i;
    assign wb_o = wb_q;

    // the producer's result is still on wb_q when a woken consumer issues
    assign src1 = (wb_q.valid && (wb_q.prd == iss.ps1)) ? wb_q.data : rf[iss.ps1];
    assign src2 = (wb_q.valid && (wb_q.prd == iss.ps2)) ? wb_q.data : rf[iss.ps2];

    always_comb begin
        case (iss.uop.op)
            OP_ADD:  result = src1 + src2;
            OP_SUB:  result = src1 - src2;
            OP_AND:  result = src1 & src2;
            OP_OR:   result = src1 | src2;
            OP_XOR:  result = src1 ^ src2;
            OP_LI:   result = iss.uop.imm;
            default: result = '0;
        endcase
    end

    // all registers read zero out of reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_q.valid) begin
            rf[wb_q.prd] <= wb_q.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q.valid   <= issue_valid_i;
            wb_q.prd     <= iss.prd;
            wb_q.rob_idx <= iss.rob_idx;
            wb_q.data    <= result;
        end
    end

endmodule

/* source/rename_map.sv */
`timescale 1ns/1ps

module rename_map
    import backend_pkg::*;
#(
    parameter int  PHYS_REGS = 16,
    localparam int TAG_W     = $clog2(PHYS_REGS)
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             alloc_i,
    input  arch_reg_t        rd_i,
    input  arch_reg_t        rs1_i,
    input  arch_reg_t        rs2_i,
    output logic [TAG_W-1:0] prd_o,
    output logic [TAG_W-1:0] ps1_o,
    output logic [TAG_W-1:0] ps2_o,
    output logic [TAG_W-1:0] old_prd_o,
    output logic             free_empty_o,
    input  logic             release_i,
    input  logic [TAG_W-1:0] release_tag_i
);

    // every arch reg always holds one tag, so the rest fit in the list
    localparam int FL_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int FL_IDX_W = $clog2(FL_DEPTH);
    localparam int FL_CNT_W = $clog2(FL_DEPTH + 1);

    logic [TAG_W-1:0]    map_q [ARCH_REGS];
    logic [TAG_W-1:0]    fl_mem [FL_DEPTH];
    logic [FL_IDX_W-1:0] fl_head;
    logic [FL_IDX_W-1:0] fl_tail;
    logic [FL_CNT_W-1:0] fl_count;

    function automatic logic [FL_IDX_W-1:0] fl_next(input logic [FL_IDX_W-1:0] ptr);
        if (ptr == FL_IDX_W'(FL_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // lookups are combinational, the new mapping lands on the accept edge
    assign prd_o        = fl_mem[fl_head];
    assign ps1_o        = map_q[rs1_i];
    assign ps2_o        = map_q[rs2_i];
    assign old_prd_o    = map_q[rd_i];
    assign free_empty_o = (fl_count == '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= TAG_W'(i);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= TAG_W'(ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= FL_CNT_W'(FL_DEPTH);
        end else begin
            if (alloc_i) begin
                map_q[rd_i] <= prd_o;
                fl_head     <= fl_next(fl_head);
            end
            // tag of an overwritten mapping comes back at retirement
            if (release_i) begin
                fl_mem[fl_tail] <= release_tag_i;
                fl_tail         <= fl_next(fl_tail);
            end
            fl_count <= fl_count + FL_CNT_W'(release_i) - FL_CNT_W'(alloc_i);
        end
    end

    a_no_alloc_empty: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        alloc_i |-> !free_empty_o
    ) else $error("rename_map: allocation with empty free list");

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (release_i && !alloc_i) |-> (fl_count != FL_CNT_W'(FL_DEPTH))
    ) else $error("rename_map: free list overflow");

endmodule

/* source/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer
    import backend_pkg::*;
#(
    parameter int  PHYS_REGS = 16,
    parameter int  ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(PHYS_REGS),
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH),
    localparam int WB_W      = 1 + TAG_W + ROB_IDX_W + DATA_W
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 alloc_i,
    input  arch_reg_t            rd_i,
    input  logic [TAG_W-1:0]     old_prd_i,
    output logic [ROB_IDX_W-1:0] alloc_idx_o,
    output logic                 full_o,
    input  logic [WB_W-1:0]      wb_i,
    output logic                 retire_valid_o,
    output retire_t              retire_o,
    input  logic                 retire_ready_i,
    output logic                 release_o,
    output logic [TAG_W-1:0]     release_tag_o
);

    typedef struct packed {
        logic                 valid;
        logic [TAG_W-1:0]     prd;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [DATA_W-1:0]    data;
    } wb_info_t;

    wb_info_t             wb;
    logic [ROB_DEPTH-1:0] in_use;
    logic [ROB_DEPTH-1:0] done;
    logic [ROB_IDX_W-1:0] head;
    logic [ROB_IDX_W-1:0] tail;
    arch_reg_t            rd_q [ROB_DEPTH];
    logic [TAG_W-1:0]     old_q [ROB_DEPTH];
    logic [DATA_W-1:0]    data_q [ROB_DEPTH];
    logic                 retire_fire;

    function automatic logic [ROB_IDX_W-1:0] rob_next(input logic [ROB_IDX_W-1:0] ptr);
        if (ptr == ROB_IDX_W'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wb          = wb_i;
    assign alloc_idx_o = tail;
    // tail only catches up with a live slot when the ring is full
    assign full_o      = in_use[tail];

    assign retire_valid_o = in_use[head] && done[head];
    assign retire_o       = '{rd: rd_q[head], data: data_q[head]};
    assign retire_fire    = retire_valid_o && retire_ready_i;
    assign release_o      = retire_fire;
    assign release_tag_o  = old_q[head];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            in_use <= '0;
            done   <= '0;
            head   <= '0;
            tail   <= '0;
        end else begin
            if (wb.valid) begin
                done[wb.rob_idx] <= 1'b1;
            end
            if (retire_fire) begin
                in_use[head] <= 1'b0;
                head         <= rob_next(head);
            end
            if (alloc_i) begin
                in_use[tail] <= 1'b1;
                done[tail]   <= 1'b0;
                tail         <= rob_next(tail);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rd_q[tail]  <= rd_i;
            old_q[tail] <= old_prd_i;
        end
        if (wb.valid) begin
            data_q[wb.rob_idx] <= wb.data;
        end
    end

    // each slot gets exactly one writeback while it is live
    a_wb_live_slot: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb.valid |-> (in_use[wb.rob_idx] && !done[wb.rob_idx])
    ) else $error("reorder_buffer: writeback to a slot that is not allocated");

endmodule

/* tb.f */
source/backend_pkg.sv
source/rename_map.sv
source/busy_table.sv
source/alu_issue_queue.sv
source/reorder_buffer.sv
source/exec_stage.sv
source/backend_top.sv
verif/tb_backend_top.sv

/* verif/tb_backend_top.sv */
`timescale 1ns/1ps

module tb_backend_top
    import backend_pkg::*;
;

    localparam int PHYS_REGS = 16;
    localparam int IQ_DEPTH  = 4;
    localparam int ROB_DEPTH = 8;

    logic    clk;
    logic    rst_n_i;
    logic    uop_valid_i;
    uop_t    uop_i;
    logic    uop_ready_o;
    logic    retire_valid_o;
    retire_t retire_o;
    logic    retire_ready_i;

    integer            seed = 32'h4d6e_fd99;
    int                value_errors = 0;
    int                other_failures = 0;
    int                ready_mode;
    logic [DATA_W-1:0] ref_regs [ARCH_REGS];
    retire_t           exp_q [$];
    logic              held_active;
    retire_t           held_val;

    backend_top #(
        .PHYS_REGS (PHYS_REGS),
        .IQ_DEPTH  (IQ_DEPTH),
        .ROB_DEPTH (ROB_DEPTH)
    ) backend_top_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .uop_valid_i    (uop_valid_i),
        .uop_i          (uop_i),
        .uop_ready_o    (uop_ready_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .retire_ready_i (retire_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic uop_t make_uop(input alu_op_e op, input arch_reg_t rd,
                                      input arch_reg_t rs1, input arch_reg_t rs2,
                                      input logic [DATA_W-1:0] imm);
        return '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm};
    endfunction

    task automatic check_retire(input retire_t got, input retire_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0d ns %s: got rd=%0d data=%h, expected rd=%0d data=%h",
                     $time, what, got.rd, got.data, exp.rd, exp.data);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0d ns %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // reference model updated in acceptance order
    task automatic push_expected(input uop_t u);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] v;
        a = ref_regs[u.rs1];
        b = ref_regs[u.rs2];
        case (u.op)
            OP_ADD:  v = a + b;
            OP_SUB:  v = a - b;
            OP_AND:  v = a & b;
            OP_OR:   v = a | b;
            OP_XOR:  v = a ^ b;
            default: v = u.imm;
        endcase
        ref_regs[u.rd] = v;
        exp_q.push_back('{rd: u.rd, data: v});
    endtask

    // called on a falling edge and leaves valid high if never accepted
    task automatic send_uop(input uop_t u, input int limit, output logic accepted);
        int waited;
        waited      = 0;
        accepted    = 1'b0;
        uop_valid_i = 1'b1;
        uop_i       = u;
        while (!uop_ready_o && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (uop_ready_o) begin
            push_expected(u);
            accepted = 1'b1;
            @(negedge clk);
            uop_valid_i = 1'b0;
        end
    endtask

    task automatic send_checked(input uop_t u);
        logic ok;
        send_uop(u, 100, ok);
        if (!ok) begin
            other_failures++;
            $display("timeout: DUT did not accept a micro-op within 100 cycles at %0d ns", $time);
        end
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            other_failures++;
            $display("timeout: %0d results still not retired after %0d cycles",
                     exp_q.size(), limit);
        end
    endtask

    // retire side picks ready on every falling edge
    initial begin
        retire_ready_i = 1'b0;
        held_active    = 1'b0;
        forever begin
            @(negedge clk);
            case (ready_mode)
                1:       retire_ready_i = 1'b0;
                2:       retire_ready_i = rand_word() > 32'h7fff_ffff;
                default: retire_ready_i = 1'b1;
            endcase
            if (rst_n_i) begin
                if (held_active) begin
                    check_bit(retire_valid_o, 1'b1, "retire valid dropped while held");
                    check_retire(retire_o, held_val, "retire data changed while held");
                end
                if (retire_valid_o && retire_ready_i) begin
                    held_active = 1'b0;
                    if (exp_q.size() == 0) begin
                        other_failures++;
                        $display("DUT retired a result with no micro-op outstanding at %0d ns",
                                 $time);
                    end else begin
                        check_retire(retire_o, exp_q.pop_front(), "retired result");
                    end
                end else if (retire_valid_o) begin
                    held_active = 1'b1;
                    held_val    = retire_o;
                end else begin
                    held_active = 1'b0;
                end
            end
        end
    end

    task automatic reset_state();
        check_bit(retire_valid_o, 1'b0, "retire valid after reset");
        check_bit(uop_ready_o, 1'b1, "uop ready after reset");
    endtask

    task automatic li_stream();
        for (int i = 0; i < ARCH_REGS; i++) begin
            send_checked(make_uop(OP_LI, 3'(i), 3'd0, 3'd0, rand_word()));
        end
        wait_drain(200);
    endtask

    // each op reads the previous destination
    task automatic dependent_chain();
        send_checked(make_uop(OP_LI,  3'd1, 3'd0, 3'd0, rand_word()));
        send_checked(make_uop(OP_LI,  3'd2, 3'd0, 3'd0, rand_word()));
        send_checked(make_uop(OP_ADD, 3'd3, 3'd1, 3'd2, 32'd0));
        send_checked(make_uop(OP_SUB, 3'd4, 3'd3, 3'd1, 32'd0));
        send_checked(make_uop(OP_AND, 3'd5, 3'd4, 3'd3, 32'd0));
        send_checked(make_uop(OP_OR,  3'd6, 3'd5, 3'd2, 32'd0));
        send_checked(make_uop(OP_XOR, 3'd7, 3'd6, 3'd4, 32'd0));
        send_checked(make_uop(OP_ADD, 3'd7, 3'd7, 3'd7, 32'd0));
        wait_drain(200);
    endtask

    task automatic war_waw_hazards();
        send_checked(make_uop(OP_LI,  3'd2, 3'd0, 3'd0, 32'h0000_1111));
        send_checked(make_uop(OP_ADD, 3'd3, 3'd2, 3'd2, 32'd0));
        // overwrite after the reader and then once more
        send_checked(make_uop(OP_LI,  3'd2, 3'd0, 3'd0, 32'h0000_2222));
        send_checked(make_uop(OP_LI,  3'd2, 3'd0, 3'd0, 32'h0000_3333));
        send_checked(make_uop(OP_XOR, 3'd4, 3'd2, 3'd3, 32'd0));
        send_checked(make_uop(OP_OR,  3'd5, 3'd2, 3'd2, 32'd0));
        wait_drain(200);
    endtask

    task automatic retire_backpressure();
        uop_t u;
        logic ok;
        int   accepted;
        int   n;
        ready_mode = 1;
        accepted   = 0;
        ok         = 1'b1;
        n          = 0;
        while (ok && n < ROB_DEPTH + 4) begin
            u = make_uop(OP_LI, 3'(n), 3'd0, 3'd0, rand_word());
            send_uop(u, 20, ok);
            if (ok) begin
                accepted++;
            end
            n++;
        end
        check_bit(ok, 1'b0, "uop ready fell under retire back-pressure");
        check_bit(accepted <= ROB_DEPTH, 1'b1, "acceptances within ROB depth");
        check_bit(retire_valid_o, 1'b1, "retire valid while ROB held");
        ready_mode = 0;
        // the stalled micro-op is still on the port
        if (!ok) begin
            send_checked(u);
        end
        for (int i = 0; i < 4; i++) begin
            send_checked(make_uop(OP_ADD, 3'(i), 3'(i + 1), 3'(i + 2), 32'd0));
        end
        wait_drain(300);
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [3:0]  op_sel;
        ready_mode = 2;
        for (int i = 0; i < 200; i++) begin
            r      = rand_word();
            op_sel = r[15:12] % 4'd6;
            send_checked(make_uop(alu_op_e'(op_sel[2:0]), r[2:0], r[5:3], r[8:6],
                                  rand_word()));
        end
        wait_drain(1000);
        ready_mode = 0;
    endtask

    initial begin
        rst_n_i     = 1'b0;
        uop_valid_i = 1'b0;
        uop_i       = '0;
        ready_mode  = 0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            ref_regs[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        reset_state();
        li_stream();
        dependent_chain();
        war_waw_hazards();
        retire_backpressure();
        random_traffic();
        repeat (4) @(negedge clk);
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_failures);
        if (value_errors == 0 && other_failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
